/* hw/filter_pkg.sv */
package filter_pkg;

	// Default sizes, overridable at the top level
	parameter int DEF_N_RULES = 8;
	parameter int DEF_HDR_DEPTH = 16;
	parameter int DEF_HDR_ALMOST = 14;
	parameter int DEF_MATCH_DEPTH = 8;
	parameter int RULE_IDX_W = 3;

	// Field positions inside the first 128-bit beat
	parameter int DST_PORT_LSB = 0;
	parameter int SRC_PORT_LSB = 16;
	parameter int DST_ADDR_LSB = 32;
	parameter int SRC_ADDR_LSB = 64;
	parameter int PROTO_LSB = 96;

	// Captured header fields, 104 bits
	typedef struct packed {
		logic [7:0] protocol;
		logic [31:0] src_addr;
		logic [31:0] dst_addr;
		logic [15:0] src_port;
		logic [15:0] dst_port;
	} header_t;

	// Header queue payload
	typedef struct packed {
		header_t hdr;
		logic [7:0] tag;
	} hdr_entry_t;

	// Match record handed to the host
	typedef struct packed {
		logic [7:0] tag;
		logic [RULE_IDX_W-1:0] rule_idx;
		logic [2:0] queue;
	} match_t;

	// One rule as written through the configuration port
	typedef struct packed {
		logic valid;
		logic [7:0] protocol;
		logic [31:0] dst_addr;
		logic [5:0] prefix_len; // 0 to 32
		logic [15:0] dst_port; // Zero matches any port
		logic [2:0] queue;
	} rule_cfg_t;

endpackage

/* hw/rule_if.sv */
`timescale 1ns/1ps

interface rule_if #(
	parameter int n_rules = 8
);

	logic [n_rules-1:0] valid;
	logic [7:0] protocol [n_rules];
	logic [31:0] dst_addr [n_rules]; // Already masked
	logic [31:0] dst_mask [n_rules];
	logic [15:0] dst_port [n_rules];
	logic [2:0] queue [n_rules];

	// Configuration side
	modport tbl (
		output valid, protocol, dst_addr, dst_mask, dst_port, queue
	);

	// Lookup side
	modport matcher (
		input valid, protocol, dst_addr, dst_mask, dst_port, queue
	);

endinterface

/* hw/rule_table.sv */
`timescale 1ns/1ps

module rule_table #(
	parameter int n_rules = 8
) (
	input logic clock,
	input logic rst,
	input logic cfg_we,
	input logic [2:0] cfg_addr,
	input filter_pkg::rule_cfg_t cfg_rule,
	rule_if.tbl rules
);

	logic [31:0] cfg_mask;

	// Left-aligned mask from a prefix length, lengths above 32 saturate
	function automatic logic [31:0] prefix_mask(input logic [5:0] len);
		logic [31:0] m;
		if (len >= 6'd32)
			m = '1;
		else
			m = ~(32'hffff_ffff >> len);
		return m;
	endfunction

	assign cfg_mask = prefix_mask(cfg_rule.prefix_len);

	// Valid bits, cleared by reset so no rule matches until written
	always_ff @(posedge clock) begin
		if (rst) begin
			rules.valid <= '0;
		end else if (cfg_we) begin
			for (int i = 0; i < n_rules; i++) begin
				if (int'(cfg_addr) == i)
					rules.valid[i] <= cfg_rule.valid;
			end
		end
	end

	// Rule fields
	always_ff @(posedge clock) begin
		if (cfg_we) begin
			for (int i = 0; i < n_rules; i++) begin
				if (int'(cfg_addr) == i) begin
					rules.protocol[i] <= cfg_rule.protocol;
					rules.dst_addr[i] <= cfg_rule.dst_addr & cfg_mask; // Pre-masked
					rules.dst_mask[i] <= cfg_mask;
					rules.dst_port[i] <= cfg_rule.dst_port;
					rules.queue[i] <= cfg_rule.queue;
				end
			end
		end
	end

	// A write beyond the table would be silently lost
	cfg_addr_in_range: assert property (
		@(posedge clock) disable iff (rst)
		cfg_we |-> (int'(cfg_addr) < n_rules)
	) else $error("rule_table: cfg_addr %0d outside %0d rules", cfg_addr, n_rules);

endmodule

/* hw/header_capture.sv */
`timescale 1ns/1ps

module header_capture (
	input logic clock,
	input logic rst,
	input logic [127:0] in_data,
	input logic in_sop,
	input logic in_eop,
	input logic in_valid,
	input logic [7:0] in_tag,
	input logic in_ready,
	output filter_pkg::hdr_entry_t hdr_entry,
	output logic hdr_write
);

	logic beat_ok;
	logic in_packet;
	filter_pkg::header_t beat_hdr;
	filter_pkg::header_t held_hdr;

	assign beat_ok = in_valid && in_ready; // Beat transfers this edge

	// Fields as they sit in the current beat
	always_comb begin
		beat_hdr.protocol = in_data[filter_pkg::PROTO_LSB +: 8];
		beat_hdr.src_addr = in_data[filter_pkg::SRC_ADDR_LSB +: 32];
		beat_hdr.dst_addr = in_data[filter_pkg::DST_ADDR_LSB +: 32];
		beat_hdr.src_port = in_data[filter_pkg::SRC_PORT_LSB +: 16];
		beat_hdr.dst_port = in_data[filter_pkg::DST_PORT_LSB +: 16];
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			in_packet <= 1'b0;
			hdr_write <= 1'b0;
		end else begin
			hdr_write <= beat_ok && in_eop; // One-cycle strobe
			if (beat_ok && in_eop)
				in_packet <= 1'b0;
			else if (beat_ok && in_sop)
				in_packet <= 1'b1;
		end
	end

	// Header held from the start beat until the end beat
	always_ff @(posedge clock) begin
		if (beat_ok && in_sop)
			held_hdr <= beat_hdr;
		if (beat_ok && in_eop) begin
			// Single-beat packet takes its fields straight from this beat
			hdr_entry.hdr <= in_sop ? beat_hdr : held_hdr;
			hdr_entry.tag <= in_tag;
		end
	end

	sop_outside_packet: assert property (
		@(posedge clock) disable iff (rst)
		(beat_ok && in_sop) |-> !in_packet
	) else $error("header_capture: start beat inside an open packet");

	eop_inside_packet: assert property (
		@(posedge clock) disable iff (rst)
		(beat_ok && in_eop && !in_sop) |-> in_packet
	) else $error("header_capture: end beat with no packet open");

endmodule

/* hw/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int depth = 16,
	parameter int almost_full_level = depth - 2
) (
	input logic clock,
	input logic rst,
	input payload_t wr_data,
	input logic wr_en,
	input logic rd_en,
	output payload_t rd_data,
	output logic empty,
	output logic full,
	output logic almost_full
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	payload_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;

	// Wraps at depth, which need not be a power of two
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
		logic [ptr_w-1:0] n;
		if (p == ptr_w'(depth - 1))
			n = '0;
		else
			n = p + 1'b1;
		return n;
	endfunction

	always_ff @(posedge clock) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= next_ptr(wr_ptr);
			if (rd_en)
				rd_ptr <= next_ptr(rd_ptr);
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
	end

	assign rd_data = mem[rd_ptr]; // Show-ahead head
	assign empty = (count == '0);
	assign full = (count == cnt_w'(depth));
	assign almost_full = (count >= cnt_w'(almost_full_level));

	no_write_when_full: assert property (
		@(posedge clock) disable iff (rst)
		!(wr_en && full)
	) else $error("sync_fifo: write while full");

	no_read_when_empty: assert property (
		@(posedge clock) disable iff (rst)
		!(rd_en && empty)
	) else $error("sync_fifo: read while empty");

endmodule

/* hw/rule_match.sv */
`timescale 1ns/1ps

module rule_match #(
	parameter int n_rules = 8
) (
	input logic clock,
	input logic rst,
	input filter_pkg::hdr_entry_t hdr_entry,
	input logic hdr_avail,
	output logic hdr_pop,
	rule_if.matcher rules,
	input logic match_full,
	output filter_pkg::match_t match_rec,
	output logic match_write
);

	logic stall;
	logic [n_rules-1:0] hits;

	// Stage 1
	logic s1_valid;
	logic [n_rules-1:0] s1_hits;
	logic [7:0] s1_tag;
	logic [2:0] s1_queue [n_rules]; // Queue fields seen with the hits

	// Stage 2
	logic s2_valid;
	logic s2_hit;
	filter_pkg::match_t s2_rec;

	logic [filter_pkg::RULE_IDX_W-1:0] sel_idx;

	// Hit or miss waits only when a hit cannot be pushed
	assign stall = s2_valid && s2_hit && match_full;
	assign hdr_pop = hdr_avail && !stall;

	// Every rule compared in parallel
	always_comb begin
		for (int i = 0; i < n_rules; i++) begin
			hits[i] = rules.valid[i]
				&& (hdr_entry.hdr.protocol == rules.protocol[i])
				&& ((hdr_entry.hdr.dst_addr & rules.dst_mask[i]) == rules.dst_addr[i])
				&& ((rules.dst_port[i] == 16'd0)
					|| (hdr_entry.hdr.dst_port == rules.dst_port[i]));
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			s1_valid <= 1'b0;
		end else if (!stall) begin
			s1_valid <= hdr_pop;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			s1_hits <= hits;
			s1_tag <= hdr_entry.tag;
			for (int i = 0; i < n_rules; i++)
				s1_queue[i] <= rules.queue[i];
		end
	end

	// Lowest index wins
	always_comb begin
		sel_idx = '0;
		for (int i = n_rules - 1; i >= 0; i--) begin
			if (s1_hits[i])
				sel_idx = filter_pkg::RULE_IDX_W'(i);
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			s2_valid <= 1'b0;
		end else if (!stall) begin
			s2_valid <= s1_valid; // A miss retires here next cycle
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			s2_hit <= |s1_hits;
			s2_rec.tag <= s1_tag;
			s2_rec.rule_idx <= sel_idx;
			s2_rec.queue <= s1_queue[sel_idx];
		end
	end

	assign match_write = s2_valid && s2_hit && !match_full;
	assign match_rec = s2_rec;

	no_push_when_full: assert property (
		@(posedge clock) disable iff (rst)
		match_write |-> !match_full
	) else $error("rule_match: push into a full match queue");

endmodule

/* hw/packet_filter.sv */
`timescale 1ns/1ps

module packet_filter #(
	parameter int n_rules = filter_pkg::DEF_N_RULES
) (
	input logic clock,
	input logic rst,
	input logic [127:0] in_data,
	input logic in_sop,
	input logic in_eop,
	input logic [7:0] in_tag,
	input logic in_valid,
	output logic in_ready,
	output filter_pkg::match_t data_out,
	output logic data_valid,
	input logic data_ack,
	input logic cfg_we,
	input logic [2:0] cfg_addr,
	input filter_pkg::rule_cfg_t cfg_rule
);

	filter_pkg::hdr_entry_t cap_entry;
	filter_pkg::hdr_entry_t hdr_head;
	logic cap_write;
	logic hdr_empty;
	logic hdr_almost;
	logic hdr_pop;

	filter_pkg::match_t match_rec;
	logic match_write;
	logic match_full;
	logic match_empty;
	logic match_pop;

	assign in_ready = !hdr_almost; // Two spare entries cover the capture register
	assign data_valid = !match_empty;
	assign match_pop = data_ack && data_valid; // Ack without a record is ignored

	header_capture capture_i (
		.clock(clock),
		.rst(rst),
		.in_data(in_data),
		.in_sop(in_sop),
		.in_eop(in_eop),
		.in_valid(in_valid),
		.in_tag(in_tag),
		.in_ready(in_ready),
		.hdr_entry(cap_entry),
		.hdr_write(cap_write)
	);

	sync_fifo #(
		.payload_t(filter_pkg::hdr_entry_t),
		.depth(filter_pkg::DEF_HDR_DEPTH),
		.almost_full_level(filter_pkg::DEF_HDR_ALMOST)
	) hdr_queue (
		.clock(clock),
		.rst(rst),
		.wr_data(cap_entry),
		.wr_en(cap_write),
		.rd_en(hdr_pop),
		.rd_data(hdr_head),
		.empty(hdr_empty),
		.full(),
		.almost_full(hdr_almost)
	);

	rule_if #(.n_rules(n_rules)) rules_i ();

	rule_table #(.n_rules(n_rules)) table_i (
		.clock(clock),
		.rst(rst),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_rule(cfg_rule),
		.rules(rules_i.tbl)
	);

	rule_match #(.n_rules(n_rules)) match_i (
		.clock(clock),
		.rst(rst),
		.hdr_entry(hdr_head),
		.hdr_avail(!hdr_empty),
		.hdr_pop(hdr_pop),
		.rules(rules_i.matcher),
		.match_full(match_full),
		.match_rec(match_rec),
		.match_write(match_write)
	);

	sync_fifo #(
		.payload_t(filter_pkg::match_t),
		.depth(filter_pkg::DEF_MATCH_DEPTH)
	) match_queue (
		.clock(clock),
		.rst(rst),
		.wr_data(match_rec),
		.wr_en(match_write),
		.rd_en(match_pop),
		.rd_data(data_out),
		.empty(match_empty),
		.full(match_full),
		.almost_full()
	);

endmodule

/* verification/tb_packet_filter.sv */
`timescale 1ns/1ps

module tb_packet_filter;

	localparam int N_RULES = 8;
	localparam int TIMEOUT_CYCLES = 200;
	localparam int IDLE_WINDOW = 20;

	logic clock;
	logic rst;
	logic [127:0] in_data;
	logic in_sop;
	logic in_eop;
	logic [7:0] in_tag;
	logic in_valid;
	logic in_ready;
	filter_pkg::match_t data_out;
	logic data_valid;
	logic data_ack;
	logic cfg_we;
	logic [2:0] cfg_addr;
	filter_pkg::rule_cfg_t cfg_rule;

	filter_pkg::rule_cfg_t mirror [N_RULES]; // Model copy of the rule table
	filter_pkg::match_t exp_q [$]; // Records still owed by the DUT, in send order
	logic [31:0] lfsr_state;

	packet_filter #(.n_rules(N_RULES)) dut_i (
		.clock(clock), .rst(rst),
		.in_data(in_data), .in_sop(in_sop), .in_eop(in_eop), .in_tag(in_tag),
		.in_valid(in_valid), .in_ready(in_ready),
		.data_out(data_out), .data_valid(data_valid), .data_ack(data_ack),
		.cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_rule(cfg_rule)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic compare_match(input string name, input filter_pkg::match_t exp,
			input filter_pkg::match_t act);
		if (act !== exp)
			abort_run($sformatf("[FAIL] %0t %s expected %h (tag %h idx %0d queue %0d) got %h",
				$time, name, exp, exp.tag, exp.rule_idx, exp.queue, act));
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("[FAIL] %0t %s expected %b got %b", $time, name, exp, act));
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic logic [7:0] proto_choice();
		return rand_bits(1) ? 8'd17 : 8'd6;
	endfunction

	function automatic logic [31:0] addr_choice();
		logic [31:0] a;
		a = 32'h0a00_0000;
		a[9:8] = 2'(rand_bits(2));
		a[1:0] = 2'(rand_bits(2));
		return a;
	endfunction

	function automatic logic [15:0] port_choice();
		case (2'(rand_bits(2)))
			2'd0: return 16'd80;
			2'd1: return 16'd443;
			2'd2: return 16'd53;
			default: return 16'd22;
		endcase
	endfunction

	function automatic logic [5:0] prefix_choice();
		case (3'(rand_bits(3)))
			3'd0: return 6'd0;
			3'd1: return 6'd8;
			3'd2: return 6'd16;
			3'd3: return 6'd22;
			3'd4: return 6'd24;
			3'd5: return 6'd30;
			3'd6: return 6'd31;
			default: return 6'd32;
		endcase
	endfunction

	function automatic filter_pkg::header_t build_header(input logic [7:0] proto,
			input logic [31:0] dst, input logic [15:0] port);
		filter_pkg::header_t h;
		h.protocol = proto;
		h.dst_addr = dst;
		h.dst_port = port;
		h.src_addr = rand_bits(32); // Never compared
		h.src_port = 16'(rand_bits(16));
		return h;
	endfunction

	function automatic filter_pkg::rule_cfg_t make_rule(input logic valid,
			input logic [7:0] proto, input logic [31:0] dst, input logic [5:0] plen,
			input logic [15:0] port, input logic [2:0] queue);
		filter_pkg::rule_cfg_t r;
		r.valid = valid;
		r.protocol = proto;
		r.dst_addr = dst;
		r.prefix_len = plen;
		r.dst_port = port;
		r.queue = queue;
		return r;
	endfunction

	function automatic filter_pkg::rule_cfg_t rule_choice();
		logic valid;
		logic [15:0] port;
		valid = (rand_bits(2) != 0); // Mostly valid
		port = rand_bits(1) ? 16'd0 : port_choice();
		return make_rule(valid, proto_choice(), addr_choice(), prefix_choice(), port,
			3'(rand_bits(3)));
	endfunction

	function automatic logic [31:0] prefix_to_mask(input logic [5:0] len);
		logic [31:0] m;
		m = '0;
		for (int b = 0; b < 32; b++)
			if (b < len) m[31-b] = 1'b1;
		return m;
	endfunction

	// First valid rule in index order wins
	task automatic model_lookup(input filter_pkg::header_t h, input logic [7:0] tag,
			output logic hit, output filter_pkg::match_t rec);
		logic [31:0] mask;
		hit = 1'b0;
		rec = '0;
		for (int i = 0; i < N_RULES; i++) begin
			mask = prefix_to_mask(mirror[i].prefix_len);
			if (!hit && mirror[i].valid && h.protocol == mirror[i].protocol
					&& (h.dst_addr & mask) == (mirror[i].dst_addr & mask)
					&& (mirror[i].dst_port == 16'd0 || h.dst_port == mirror[i].dst_port)) begin
				hit = 1'b1;
				rec.tag = tag;
				rec.rule_idx = filter_pkg::RULE_IDX_W'(i);
				rec.queue = mirror[i].queue;
			end
		end
	endtask

	function automatic logic [127:0] header_beat(input filter_pkg::header_t h);
		logic [127:0] d;
		d = '0;
		d[filter_pkg::PROTO_LSB +: 8] = h.protocol;
		d[filter_pkg::SRC_ADDR_LSB +: 32] = h.src_addr;
		d[filter_pkg::DST_ADDR_LSB +: 32] = h.dst_addr;
		d[filter_pkg::SRC_PORT_LSB +: 16] = h.src_port;
		d[filter_pkg::DST_PORT_LSB +: 16] = h.dst_port;
		return d;
	endfunction

	task automatic write_rule(input int idx, input filter_pkg::rule_cfg_t r);
		@(negedge clock);
		cfg_we = 1'b1;
		cfg_addr = 3'(idx);
		cfg_rule = r;
		@(negedge clock);
		cfg_we = 1'b0;
		mirror[idx] = r;
	endtask

	task automatic send_packet(input filter_pkg::header_t h, input logic [7:0] tag,
			input int beats);
		logic hit;
		filter_pkg::match_t rec;
		int waited;
		model_lookup(h, tag, hit, rec);
		if (hit)
			exp_q.push_back(rec);
		for (int b = 0; b < beats; b++) begin
			@(negedge clock);
			in_valid = 1'b1;
			in_sop = (b == 0);
			in_eop = (b == beats - 1);
			in_tag = (b == beats - 1) ? tag : ~tag; // Tag only counts on the end beat
			in_data = (b == 0) ? header_beat(h) : {4{rand_bits(32)}};
			waited = 0;
			while (!in_ready) begin
				@(negedge clock);
				waited++;
				if (waited > TIMEOUT_CYCLES)
					abort_run("Timed out waiting for in_ready while sending a packet");
			end
			@(posedge clock); // Beat transfers here
		end
		@(negedge clock);
		in_valid = 1'b0;
		in_sop = 1'b0;
		in_eop = 1'b0;
	endtask

	task automatic expect_match();
		filter_pkg::match_t exp;
		int waited;
		waited = 0;
		@(negedge clock);
		while (!data_valid) begin
			@(negedge clock);
			waited++;
			if (waited > TIMEOUT_CYCLES)
				abort_run("Timed out waiting for data_valid on an expected match record");
		end
		if (exp_q.size() == 0)
			abort_run("A match record came out while none was expected");
		exp = exp_q.pop_front();
		compare_match("data_out", exp, data_out);
		data_ack = 1'b1;
		@(negedge clock);
		data_ack = 1'b0;
	endtask

	task automatic expect_idle();
		if (exp_q.size() != 0)
			abort_run("Expected match records were never read before the idle check");
		repeat (IDLE_WINDOW) begin
			@(negedge clock);
			compare_bit("data_valid", 1'b0, data_valid);
		end
	endtask

	task automatic reset_state_test();
		compare_bit("data_valid", 1'b0, data_valid);
		compare_bit("in_ready", 1'b1, in_ready);
		send_packet(build_header(8'd6, 32'h0a01_0203, 16'd80), 8'h11, 1);
		expect_idle();
	endtask

	task automatic single_rule_test();
		write_rule(2, make_rule(1'b1, 8'd6, 32'h0a01_0200, 6'd24, 16'd80, 3'd5));
		send_packet(build_header(8'd6, 32'h0a01_0207, 16'd80), 8'h21, 1);
		expect_match();
		send_packet(build_header(8'd6, 32'h0a01_02fe, 16'd80), 8'h22, 4);
		expect_match();
	endtask

	task automatic priority_test();
		write_rule(1, make_rule(1'b1, 8'd17, 32'hc0a8_0100, 6'd24, 16'd53, 3'd3));
		write_rule(5, make_rule(1'b1, 8'd17, 32'h0, 6'd0, 16'd0, 3'd6)); // Wildcard
		send_packet(build_header(8'd17, 32'hc0a8_0107, 16'd53), 8'h31, 1);
		expect_match();
		send_packet(build_header(8'd17, 32'h0a09_0909, 16'd1234), 8'h32, 2);
		expect_match();
		send_packet(build_header(8'd1, 32'hc0a8_0107, 16'd53), 8'h33, 1); // Protocol miss
		send_packet(build_header(8'd17, 32'hc0a8_0108, 16'd53), 8'h34, 3);
		expect_match();
		expect_idle();
	endtask

	// 8 records in the match queue plus 1 hit held in stage 2 plus 14 queued headers
	task automatic backpressure_test();
		for (int i = 0; i < 23; i++)
			send_packet(build_header(8'd17, 32'h0a00_0000 | i, 16'(1000 + i)),
				8'(8'h40 + i), 1 + i % 3);
		repeat (10) @(negedge clock);
		compare_bit("in_ready", 1'b0, in_ready);
		compare_bit("data_valid", 1'b1, data_valid);
		fork
			for (int i = 23; i < 30; i++)
				send_packet(build_header(8'd17, 32'h0a00_0000 | i, 16'(1000 + i)),
					8'(8'h40 + i), 2);
			repeat (30) expect_match();
		join
		expect_idle();
	endtask

	task automatic rule_update_test();
		write_rule(1, make_rule(1'b0, 8'd17, 32'hc0a8_0100, 6'd24, 16'd53, 3'd3));
		send_packet(build_header(8'd17, 32'hc0a8_0107, 16'd53), 8'h51, 1);
		expect_match();
		write_rule(5, make_rule(1'b1, 8'd17, 32'h0, 6'd0, 16'd0, 3'd2));
		send_packet(build_header(8'd17, 32'hc0a8_0107, 16'd53), 8'h52, 1);
		expect_match();
		write_rule(5, make_rule(1'b0, 8'd17, 32'h0, 6'd0, 16'd0, 3'd2));
		send_packet(build_header(8'd17, 32'hc0a8_0107, 16'd53), 8'h53, 1);
		expect_idle();
	endtask

	task automatic random_test();
		filter_pkg::header_t h;
		logic [7:0] tag;
		int beats;
		for (int i = 0; i < N_RULES; i++)
			write_rule(i, rule_choice());
		for (int n = 0; n < 200; n++) begin
			if (n > 0 && n % 50 == 0) begin
				repeat (10) @(negedge clock); // Let misses retire first
				write_rule(int'(rand_bits(3)), rule_choice());
			end
			h = build_header(proto_choice(), addr_choice(), port_choice());
			tag = 8'(rand_bits(8));
			beats = 1 + int'(rand_bits(2));
			send_packet(h, tag, beats);
			if (exp_q.size() > 0)
				expect_match();
		end
		expect_idle();
	endtask

	initial begin
		lfsr_state = 32'h52b8;
		rst = 1'b1;
		in_data = '0;
		in_sop = 1'b0;
		in_eop = 1'b0;
		in_tag = '0;
		in_valid = 1'b0;
		data_ack = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_rule = '0;
		for (int i = 0; i < N_RULES; i++)
			mirror[i] = '0; // Reset leaves every rule invalid
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		reset_state_test();
		single_rule_test();
		priority_test();
		backpressure_test();
		rule_update_test();
		random_test();
		$display("Regression passed");
		$finish;
	end

endmodule

/* compile.f */
hw/filter_pkg.sv
hw/rule_if.sv
hw/rule_table.sv
hw/header_capture.sv
hw/sync_fifo.sv
hw/rule_match.sv
hw/packet_filter.sv
verification/tb_packet_filter.sv

/* Bender.yml */
package:
  name: packet_filter

sources:
  - hw/filter_pkg.sv
  - hw/rule_if.sv
  - hw/rule_table.sv
  - hw/header_capture.sv
  - hw/sync_fifo.sv
  - hw/rule_match.sv
  - hw/packet_filter.sv
  - target: test
    files:
      - verification/tb_packet_filter.sv
